// File: Makefile
TOOL      = verilator
FLAGS     = --timing --assert
TOP       = tb_decode_execute
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/decode_execute.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// decode_execute
// decode to execute boundary of the pipeline with
// hazard bubbles and decode stage branch resolution
//////////////////////////////////////////////////
module decode_execute (
  input  logic                clk,
  input  logic                rst,
  input  logic                padv_i,
  input  logic                pipeline_flush_i,
  input  dx_pkg::operand_t    pc_decode_i,
  input  dx_pkg::dec_ops_t    decode_ops_i,
  input  dx_pkg::dec_data_t   decode_data_i,
  input  dx_pkg::dec_except_t decode_except_i,
  input  dx_pkg::rf_adr_t     decode_rfa_adr_i,
  input  dx_pkg::rf_adr_t     decode_rfb_adr_i,
  input  dx_pkg::operand_t    decode_rfb_i,
  input  dx_pkg::operand_t    execute_rfb_i,
  input  logic                predicted_flag_i,
  input  dx_pkg::rf_adr_t     ctrl_rfd_adr_i,
  input  logic                ctrl_op_lsu_load_i,
  input  logic                ctrl_op_mfspr_i,
  output dx_pkg::dec_ops_t    execute_ops_o,
  output dx_pkg::dec_data_t   execute_data_o,
  output dx_pkg::dec_except_t execute_except_o,
  output dx_pkg::operand_t    pc_execute_o,
  output dx_pkg::operand_t    execute_jal_result_o,
  output logic                execute_predicted_flag_o,
  output dx_pkg::operand_t    execute_mispredict_target_o,
  output logic                decode_branch_o,
  output dx_pkg::operand_t    decode_branch_target_o,
  output logic                decode_bubble_o,
  output logic                execute_bubble_o,
  output logic                decode_valid_o
);
  import dx_pkg::*;

  logic     jr_wait;
  logic     decode_ibus_align;
  operand_t next_pc;
  operand_t mispredict_target;

  dx_hazard_detect hazard_detect_i (
    .padv_i            (padv_i),
    .decode_ops_i      (decode_ops_i),
    .decode_rfa_adr_i  (decode_rfa_adr_i),
    .decode_rfb_adr_i  (decode_rfb_adr_i),
    .execute_ops_i     (execute_ops_o),
    .execute_rfd_adr_i (execute_data_o.rfd_adr),
    .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
    .ctrl_op_lsu_load_i(ctrl_op_lsu_load_i),
    .ctrl_op_mfspr_i   (ctrl_op_mfspr_i),
    .decode_bubble_o   (decode_bubble_o),
    .jr_wait_o         (jr_wait)
  );

  dx_branch_resolve branch_resolve_i (
    .pc_decode_i           (pc_decode_i),
    .decode_ops_i          (decode_ops_i),
    .decode_data_i         (decode_data_i),
    .predicted_flag_i      (predicted_flag_i),
    .jr_wait_i             (jr_wait),
    .pipeline_flush_i      (pipeline_flush_i),
    .decode_rfb_i          (decode_rfb_i),
    .execute_rfb_i         (execute_rfb_i),
    .execute_bubble_i      (execute_bubble_o),
    .execute_jr_i          (execute_ops_o.jr),
    .decode_branch_o       (decode_branch_o),
    .decode_branch_target_o(decode_branch_target_o),
    .decode_ibus_align_o   (decode_ibus_align),
    .next_pc_o             (next_pc),
    .mispredict_target_o   (mispredict_target)
  );

  dx_stage_regs stage_regs_i (
    .clk                        (clk),
    .rst                        (rst),
    .padv_i                     (padv_i),
    .pipeline_flush_i           (pipeline_flush_i),
    .decode_bubble_i            (decode_bubble_o),
    .pc_decode_i                (pc_decode_i),
    .decode_ops_i               (decode_ops_i),
    .decode_data_i              (decode_data_i),
    .decode_except_i            (decode_except_i),
    .decode_ibus_align_i        (decode_ibus_align),
    .next_pc_i                  (next_pc),
    .mispredict_target_i        (mispredict_target),
    .predicted_flag_i           (predicted_flag_i),
    .execute_ops_o              (execute_ops_o),
    .execute_data_o             (execute_data_o),
    .execute_except_o           (execute_except_o),
    .pc_execute_o               (pc_execute_o),
    .execute_jal_result_o       (execute_jal_result_o),
    .execute_predicted_flag_o   (execute_predicted_flag_o),
    .execute_mispredict_target_o(execute_mispredict_target_o),
    .execute_bubble_o           (execute_bubble_o),
    .decode_valid_o             (decode_valid_o)
  );

endmodule

// File: hdl/dx_branch_resolve.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// dx_branch_resolve
// resolves jumps and branches in decode and forms
// the fall-through and mispredict addresses
//////////////////////////////////////////////////
module dx_branch_resolve (
  input  dx_pkg::operand_t  pc_decode_i,
  input  dx_pkg::dec_ops_t  decode_ops_i,
  input  dx_pkg::dec_data_t decode_data_i,
  input  logic              predicted_flag_i,
  input  logic              jr_wait_i,
  input  logic              pipeline_flush_i,
  input  dx_pkg::operand_t  decode_rfb_i,
  input  dx_pkg::operand_t  execute_rfb_i,
  input  logic              execute_bubble_i,
  input  logic              execute_jr_i,
  output logic              decode_branch_o,
  output dx_pkg::operand_t  decode_branch_target_o,
  output logic              decode_ibus_align_o,
  output dx_pkg::operand_t  next_pc_o,
  output dx_pkg::operand_t  mispredict_target_o
);
  import dx_pkg::*;

  logic     uncond;
  logic     branch_to_imm;
  logic     branch_to_reg;
  logic     mispredict_to_imm;
  operand_t imm_offset;
  operand_t imm_target;
  operand_t reg_target;

  // word offset from the split jump immediate
  assign imm_offset = {{IMMJBR_SEXT_WIDTH{decode_data_i.immjbr_upper[IMMJBR_UPPER_WIDTH-1]}},
                       decode_data_i.immjbr_upper,
                       decode_data_i.imm16,
                       2'b00};
  assign imm_target = pc_decode_i + imm_offset;

  // l.j and l.jal
  assign uncond = ~|decode_ops_i.opc_insn[BRCOND_FLAG_BIT:BRCOND_LOW_BIT];

  // bf and bnf follow the predicted flag
  assign branch_to_imm = decode_ops_i.jbr &
                         (uncond |
                          (decode_ops_i.opc_insn[BRCOND_FLAG_BIT] == predicted_flag_i));

  assign branch_to_reg = decode_ops_i.jr & ~jr_wait_i;

  // after a bubble or a back to back jr the
  // target value sits in execute
  assign reg_target = (execute_bubble_i | execute_jr_i) ? execute_rfb_i : decode_rfb_i;

  assign decode_branch_o        = (branch_to_imm | branch_to_reg) & ~pipeline_flush_i;
  assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;

  assign decode_ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

  assign next_pc_o = pc_decode_i + OPERAND_WIDTH'(DELAY_SLOT_OFFSET);

  // recovery address if the predicted flag turns out wrong
  assign mispredict_to_imm   = (decode_ops_i.bf & ~predicted_flag_i) |
                               (decode_ops_i.bnf & predicted_flag_i);
  assign mispredict_target_o = mispredict_to_imm ? imm_target : next_pc_o;

endmodule

// File: hdl/dx_hazard_detect.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// dx_hazard_detect
// flags hazards that bypassing cannot cover and
// holds back a jump-to-register on a late result
//////////////////////////////////////////////////
module dx_hazard_detect (
  input  logic             padv_i,
  input  dx_pkg::dec_ops_t decode_ops_i,
  input  dx_pkg::rf_adr_t  decode_rfa_adr_i,
  input  dx_pkg::rf_adr_t  decode_rfb_adr_i,
  input  dx_pkg::dec_ops_t execute_ops_i,
  input  dx_pkg::rf_adr_t  execute_rfd_adr_i,
  input  dx_pkg::rf_adr_t  ctrl_rfd_adr_i,
  input  logic             ctrl_op_lsu_load_i,
  input  logic             ctrl_op_mfspr_i,
  output logic             decode_bubble_o,
  output logic             jr_wait_o
);

  logic ctrl_interlock;
  logic exec_interlock;
  logic exec_writes_rfb;

  // load or mfspr in ctrl still owes a decode operand
  assign ctrl_interlock = (ctrl_op_lsu_load_i | ctrl_op_mfspr_i) &
                          ((decode_rfa_adr_i == ctrl_rfd_adr_i) |
                           (decode_rfb_adr_i == ctrl_rfd_adr_i));

  // load or mfspr in execute only delivers its result in ctrl
  assign exec_interlock = (execute_ops_i.lsu_load | execute_ops_i.mfspr) &
                          ((decode_rfa_adr_i == execute_rfd_adr_i) |
                           (decode_rfb_adr_i == execute_rfd_adr_i));

  assign exec_writes_rfb = execute_ops_i.rf_wb & (decode_rfb_adr_i == execute_rfd_adr_i);

  // jr target register is not ready yet
  assign jr_wait_o = decode_ops_i.jr & (ctrl_interlock | exec_writes_rfb);

  // rfe always stalls fetch while it walks up to ctrl
  assign decode_bubble_o = padv_i & (exec_interlock | jr_wait_o | decode_ops_i.rfe);

endmodule

// File: hdl/dx_pkg.sv
//////////////////////////////////////////////////
// dx_pkg
// widths, opcode constants and stage structs
// shared by the decode to execute boundary
//////////////////////////////////////////////////
package dx_pkg;

  localparam int OPERAND_WIDTH      = 32;
  localparam int RF_ADDR_WIDTH      = 5;
  localparam int IMM16_WIDTH        = 16;
  localparam int IMMJBR_UPPER_WIDTH = 10;
  localparam int OPCODE_WIDTH       = 6;
  localparam int ALU_OPC_WIDTH      = 4;
  localparam int LSU_LEN_WIDTH      = 2;

  // sign bits above the word aligned jump offset
  localparam int IMMJBR_SEXT_WIDTH = OPERAND_WIDTH - IMMJBR_UPPER_WIDTH - IMM16_WIDTH - 2;

  localparam logic [OPCODE_WIDTH-1:0] OPCODE_NOP = 6'h05;

  localparam int INSN_BYTES        = 4;
  // branch plus its delay slot
  localparam int DELAY_SLOT_OFFSET = 2 * INSN_BYTES;

  // conditional branch bits of opc_insn
  // both zero means unconditional, else the flag bit gives the taken value
  localparam int BRCOND_FLAG_BIT = 2;
  localparam int BRCOND_LOW_BIT  = 1;

  typedef logic [OPERAND_WIDTH-1:0] operand_t;
  typedef logic [RF_ADDR_WIDTH-1:0] rf_adr_t;

  typedef struct packed {
    logic rf_wb;
    logic alu;
    logic add;
    logic adder_do_sub;
    logic adder_do_carry;
    logic shift;
    logic ffl1;
    logic movhi;
    logic ext;
    logic setflag;
    logic jbr;
    logic jr;
    logic jal;
    logic bf;
    logic bnf;
    logic brcond;
    logic branch;
    logic lsu_load;
    logic lsu_store;
    logic mfspr;
    logic mtspr;
    logic mul;
    logic div;
    logic msync;
    logic rfe;
    logic [OPCODE_WIDTH-1:0] opc_insn;
  } dec_ops_t;

  typedef struct packed {
    logic [ALU_OPC_WIDTH-1:0]      opc_alu;
    logic [IMM16_WIDTH-1:0]        imm16;
    operand_t                      immediate;
    logic                          immediate_sel;
    logic [IMMJBR_UPPER_WIDTH-1:0] immjbr_upper;
    rf_adr_t                       rfd_adr;
    logic [LSU_LEN_WIDTH-1:0]      lsu_length;
    logic                          lsu_zext;
  } dec_data_t;

  typedef struct packed {
    logic ibus_err;
    logic illegal;
    logic ibus_align;
  } dec_except_t;

  // empty execute slot
  localparam dec_ops_t OPS_CLEARED = '{opc_insn: OPCODE_NOP, default: 1'b0};

endpackage

// File: hdl/dx_stage_regs.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// dx_stage_regs
// decode to execute pipeline registers with
// flush, bubble and advance handling
//////////////////////////////////////////////////
module dx_stage_regs (
  input  logic                clk,
  input  logic                rst,
  input  logic                padv_i,
  input  logic                pipeline_flush_i,
  input  logic                decode_bubble_i,
  input  dx_pkg::operand_t    pc_decode_i,
  input  dx_pkg::dec_ops_t    decode_ops_i,
  input  dx_pkg::dec_data_t   decode_data_i,
  input  dx_pkg::dec_except_t decode_except_i,
  input  logic                decode_ibus_align_i,
  input  dx_pkg::operand_t    next_pc_i,
  input  dx_pkg::operand_t    mispredict_target_i,
  input  logic                predicted_flag_i,
  output dx_pkg::dec_ops_t    execute_ops_o,
  output dx_pkg::dec_data_t   execute_data_o,
  output dx_pkg::dec_except_t execute_except_o,
  output dx_pkg::operand_t    pc_execute_o,
  output dx_pkg::operand_t    execute_jal_result_o,
  output logic                execute_predicted_flag_o,
  output dx_pkg::operand_t    execute_mispredict_target_o,
  output logic                execute_bubble_o,
  output logic                decode_valid_o
);
  import dx_pkg::*;

  dec_ops_t    bubble_ops;
  dec_except_t except_in;

  // rfe rides through a bubble so it still reaches ctrl
  always_comb begin
    bubble_ops     = OPS_CLEARED;
    bubble_ops.rfe = decode_ops_i.rfe;
  end

  // alignment fault is taken from branch resolution
  always_comb begin
    except_in            = decode_except_i;
    except_in.ibus_align = decode_ibus_align_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_ops_o <= OPS_CLEARED;
    end else if (pipeline_flush_i) begin
      execute_ops_o <= OPS_CLEARED;
    end else if (padv_i) begin
      execute_ops_o <= decode_bubble_i ? bubble_ops : decode_ops_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_bubble_o <= 1'b0;
    end else if (pipeline_flush_i) begin
      execute_bubble_o <= 1'b0;
    end else if (padv_i) begin
      execute_bubble_o <= decode_bubble_i;
    end
  end

  // exceptions stay with their instruction through a flush
  always_ff @(posedge clk) begin
    if (rst) begin
      execute_except_o <= '0;
    end else if (padv_i) begin
      execute_except_o <= except_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_valid_o <= 1'b0;
    end else begin
      decode_valid_o <= padv_i;
    end
  end

  always_ff @(posedge clk) begin
    if (padv_i) begin
      execute_data_o       <= decode_data_i;
      pc_execute_o         <= pc_decode_i;
      // link value for jal
      execute_jal_result_o <= next_pc_i;
    end
  end

  // prediction state only moves with a conditional branch
  always_ff @(posedge clk) begin
    if (padv_i & decode_ops_i.brcond) begin
      execute_predicted_flag_o    <= predicted_flag_i;
      execute_mispredict_target_o <= mispredict_target_i;
    end
  end

endmodule

// File: sim.f
+incdir+include
hdl/dx_pkg.sv
hdl/dx_hazard_detect.sv
hdl/dx_branch_resolve.sv
hdl/dx_stage_regs.sv
hdl/decode_execute.sv
tests/tb_decode_execute.sv

// File: include/dx_tb_model.svh
//////////////////////////////////////////////////
// decode to execute reference model
// combinational rules and expected register
// state update for the testbench
//////////////////////////////////////////////////
`ifndef DX_TB_MODEL_SVH
`define DX_TB_MODEL_SVH

// include after importing dx_pkg

// decode side inputs of one cycle
typedef struct packed {
  logic        padv;
  logic        flush;
  operand_t    pc;
  dec_ops_t    ops;
  dec_data_t   data;
  dec_except_t exc;
  rf_adr_t     rfa_adr;
  rf_adr_t     rfb_adr;
  operand_t    decode_rfb;
  operand_t    execute_rfb;
  logic        pred_flag;
  rf_adr_t     ctrl_rfd_adr;
  logic        ctrl_load;
  logic        ctrl_mfspr;
} dx_model_in_t;

// expected execute side registers
typedef struct packed {
  dec_ops_t    ops;
  dec_data_t   data;
  dec_except_t exc;
  operand_t    pc;
  operand_t    jal_result;
  logic        pred_flag;
  operand_t    mispredict_target;
  logic        bubble;
  logic        valid;
} dx_model_t;

function automatic logic jr_must_wait(dx_model_in_t din, dx_model_t st);
  logic ctrl_hit;
  logic exec_hit;
  ctrl_hit = (din.ctrl_load | din.ctrl_mfspr) &
             ((din.rfa_adr == din.ctrl_rfd_adr) | (din.rfb_adr == din.ctrl_rfd_adr));
  exec_hit = st.ops.rf_wb & (din.rfb_adr == st.data.rfd_adr);
  return din.ops.jr & (ctrl_hit | exec_hit);
endfunction

function automatic logic bubble_needed(dx_model_in_t din, dx_model_t st);
  logic late;
  late = (st.ops.lsu_load | st.ops.mfspr) &
         ((din.rfa_adr == st.data.rfd_adr) | (din.rfb_adr == st.data.rfd_adr));
  return din.padv & (late | jr_must_wait(din, st) | din.ops.rfe);
endfunction

function automatic operand_t imm_target_addr(dx_model_in_t din);
  operand_t offset;
  offset = {{IMMJBR_SEXT_WIDTH{din.data.immjbr_upper[IMMJBR_UPPER_WIDTH-1]}},
            din.data.immjbr_upper, din.data.imm16, 2'b00};
  return din.pc + offset;
endfunction

function automatic logic imm_branch_taken(dx_model_in_t din);
  return din.ops.jbr & ((din.ops.opc_insn[BRCOND_FLAG_BIT:BRCOND_LOW_BIT] == 2'b00) |
                        (din.ops.opc_insn[BRCOND_FLAG_BIT] == din.pred_flag));
endfunction

function automatic logic branch_taken(dx_model_in_t din, dx_model_t st);
  logic reg_taken;
  reg_taken = din.ops.jr & ~jr_must_wait(din, st);
  return (imm_branch_taken(din) | reg_taken) & ~din.flush;
endfunction

function automatic operand_t branch_target_addr(dx_model_in_t din, dx_model_t st);
  if (imm_branch_taken(din)) begin
    return imm_target_addr(din);
  end
  return (st.bubble | st.ops.jr) ? din.execute_rfb : din.decode_rfb;
endfunction

function automatic operand_t mispredict_addr(dx_model_in_t din);
  if ((din.ops.bf & ~din.pred_flag) | (din.ops.bnf & din.pred_flag)) begin
    return imm_target_addr(din);
  end
  return din.pc + OPERAND_WIDTH'(DELAY_SLOT_OFFSET);
endfunction

function automatic dx_model_t reset_state();
  dx_model_t st;
  st        = 'x;
  st.ops    = OPS_CLEARED;
  st.exc    = '0;
  st.bubble = 1'b0;
  st.valid  = 1'b0;
  return st;
endfunction

// next registered state from this cycle's inputs
function automatic dx_model_t next_state(dx_model_in_t din, dx_model_t st);
  dx_model_t nx;
  logic      bubble;
  operand_t  target;
  nx       = st;
  bubble   = bubble_needed(din, st);
  target   = branch_target_addr(din, st);
  nx.valid = din.padv;
  if (din.flush) begin
    nx.ops    = OPS_CLEARED;
    nx.bubble = 1'b0;
  end else if (din.padv) begin
    nx.ops     = bubble ? OPS_CLEARED : din.ops;
    nx.ops.rfe = din.ops.rfe;
    nx.bubble  = bubble;
  end
  if (din.padv) begin
    nx.data           = din.data;
    nx.pc             = din.pc;
    nx.jal_result     = din.pc + OPERAND_WIDTH'(DELAY_SLOT_OFFSET);
    nx.exc            = din.exc;
    nx.exc.ibus_align = branch_taken(din, st) & (|target[1:0]);
    if (din.ops.brcond) begin
      nx.pred_flag         = din.pred_flag;
      nx.mispredict_target = mispredict_addr(din);
    end
  end
  return nx;
endfunction

`endif

// File: tests/tb_decode_execute.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// tb_decode_execute
// seeded random stimulus for the decode to execute
// boundary, checked every cycle against a model
//////////////////////////////////////////////////
module tb_decode_execute;
  import dx_pkg::*;

  `include "dx_tb_model.svh"

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CYCLES   = 2000;
  localparam int WATCHDOG_NS  = 2 * (NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  // jump, jal, bnf and bf major opcodes
  localparam logic [OPCODE_WIDTH-1:0] OPC_J   = 6'h00;
  localparam logic [OPCODE_WIDTH-1:0] OPC_JAL = 6'h01;
  localparam logic [OPCODE_WIDTH-1:0] OPC_BNF = 6'h03;
  localparam logic [OPCODE_WIDTH-1:0] OPC_BF  = 6'h04;

  logic        clk = 1'b0;
  logic        rst;
  logic        padv_i;
  logic        pipeline_flush_i;
  operand_t    pc_decode_i;
  dec_ops_t    decode_ops_i;
  dec_data_t   decode_data_i;
  dec_except_t decode_except_i;
  rf_adr_t     decode_rfa_adr_i;
  rf_adr_t     decode_rfb_adr_i;
  operand_t    decode_rfb_i;
  operand_t    execute_rfb_i;
  logic        predicted_flag_i;
  rf_adr_t     ctrl_rfd_adr_i;
  logic        ctrl_op_lsu_load_i;
  logic        ctrl_op_mfspr_i;

  dec_ops_t    execute_ops_o;
  dec_data_t   execute_data_o;
  dec_except_t execute_except_o;
  operand_t    pc_execute_o;
  operand_t    execute_jal_result_o;
  logic        execute_predicted_flag_o;
  operand_t    execute_mispredict_target_o;
  logic        decode_branch_o;
  operand_t    decode_branch_target_o;
  logic        decode_bubble_o;
  logic        execute_bubble_o;
  logic        decode_valid_o;

  integer       seed;
  int           errors;
  int           checks;
  dx_model_in_t din;
  dx_model_t    st;
  // unreset registers are only compared once loaded
  logic         data_seen;
  logic         pred_seen;

  decode_execute decode_execute_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // mostly word aligned with a stray low bit pair now and then
  function automatic operand_t rand_addr();
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    return {r[31:2], (s[2:0] == 3'b000) ? s[4:3] : 2'b00};
  endfunction

  task automatic drive_random_inputs();
    dec_ops_t    ops;
    dec_data_t   data;
    logic [31:0] r;
    logic [31:0] s;
    logic [95:0] wide;
    r    = next_rand();
    s    = next_rand();
    wide = {next_rand(), next_rand(), next_rand()};
    ops  = r[$bits(dec_ops_t)-1:0];
    case (s[1:0])
      2'd0:    ops.opc_insn = OPC_J;
      2'd1:    ops.opc_insn = OPC_JAL;
      2'd2:    ops.opc_insn = OPC_BNF;
      default: ops.opc_insn = OPC_BF;
    endcase
    // rfe stalls on every advance so it stays rare
    ops.rfe = (s[4:2] == 3'b000);
    data         = wide[$bits(dec_data_t)-1:0];
    data.rfd_adr = {3'b000, s[30:29]};
    padv_i             <= (s[6:5] != 2'b00);
    pipeline_flush_i   <= (s[14:7] < 8'd13);
    decode_ops_i       <= ops;
    decode_data_i      <= data;
    decode_except_i    <= s[17:15];
    decode_rfa_adr_i   <= {3'b000, s[19:18]};
    decode_rfb_adr_i   <= {3'b000, s[21:20]};
    ctrl_rfd_adr_i     <= {3'b000, s[23:22]};
    ctrl_op_lsu_load_i <= (s[25:24] == 2'b00);
    ctrl_op_mfspr_i    <= (s[27:26] == 2'b00);
    predicted_flag_i   <= s[28];
    pc_decode_i        <= rand_addr();
    decode_rfb_i       <= rand_addr();
    execute_rfb_i      <= rand_addr();
  endtask

  function automatic dx_model_in_t sample_inputs();
    dx_model_in_t d;
    d.padv         = padv_i;
    d.flush        = pipeline_flush_i;
    d.pc           = pc_decode_i;
    d.ops          = decode_ops_i;
    d.data         = decode_data_i;
    d.exc          = decode_except_i;
    d.rfa_adr      = decode_rfa_adr_i;
    d.rfb_adr      = decode_rfb_adr_i;
    d.decode_rfb   = decode_rfb_i;
    d.execute_rfb  = execute_rfb_i;
    d.pred_flag    = predicted_flag_i;
    d.ctrl_rfd_adr = ctrl_rfd_adr_i;
    d.ctrl_load    = ctrl_op_lsu_load_i;
    d.ctrl_mfspr   = ctrl_op_mfspr_i;
    return d;
  endfunction

  task automatic compare_field(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    compare_field("decode_bubble_o", 128'(decode_bubble_o), 128'(bubble_needed(din, st)));
    compare_field("decode_branch_o", 128'(decode_branch_o), 128'(branch_taken(din, st)));
    compare_field("decode_branch_target_o", 128'(decode_branch_target_o),
                  128'(branch_target_addr(din, st)));
    compare_field("execute_ops_o", 128'(execute_ops_o), 128'(st.ops));
    compare_field("execute_except_o", 128'(execute_except_o), 128'(st.exc));
    compare_field("execute_bubble_o", 128'(execute_bubble_o), 128'(st.bubble));
    compare_field("decode_valid_o", 128'(decode_valid_o), 128'(st.valid));
    if (data_seen) begin
      compare_field("execute_data_o", 128'(execute_data_o), 128'(st.data));
      compare_field("pc_execute_o", 128'(pc_execute_o), 128'(st.pc));
      compare_field("execute_jal_result_o", 128'(execute_jal_result_o),
                    128'(st.jal_result));
    end
    if (pred_seen) begin
      compare_field("execute_predicted_flag_o", 128'(execute_predicted_flag_o),
                    128'(st.pred_flag));
      compare_field("execute_mispredict_target_o", 128'(execute_mispredict_target_o),
                    128'(st.mispredict_target));
    end
  endtask

  // inputs move on the rising edge and settle by the falling edge
  always @(negedge clk) begin
    if (rst) begin
      st        = reset_state();
      data_seen = 1'b0;
      pred_seen = 1'b0;
    end else begin
      din = sample_inputs();
      check_outputs();
      st = next_state(din, st);
      if (din.padv) begin
        data_seen = 1'b1;
      end
      if (din.padv && din.ops.brcond) begin
        pred_seen = 1'b1;
      end
    end
  end

  initial begin
    seed               = 30;
    errors             = 0;
    checks             = 0;
    rst                <= 1'b1;
    padv_i             <= 1'b0;
    pipeline_flush_i   <= 1'b0;
    pc_decode_i        <= '0;
    decode_ops_i       <= OPS_CLEARED;
    decode_data_i      <= '0;
    decode_except_i    <= '0;
    decode_rfa_adr_i   <= '0;
    decode_rfb_adr_i   <= '0;
    decode_rfb_i       <= '0;
    execute_rfb_i      <= '0;
    predicted_flag_i   <= 1'b0;
    ctrl_rfd_adr_i     <= '0;
    ctrl_op_lsu_load_i <= 1'b0;
    ctrl_op_mfspr_i    <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    drive_random_inputs();
    for (int i = 1; i < NUM_CYCLES; i++) begin
      @(posedge clk);
      drive_random_inputs();
    end
    // let the last cycle be checked
    @(posedge clk);
    @(posedge clk);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule
